// ==== src/dsp_mac_pkg.sv ====
/*
 * Shared widths and packed struct types for the 20x18 MAC slice.
 * Covers the command word, the decoded op, result-stage controls
 * and the execute-stage output.
 */

package dsp_mac_pkg;

    // Datapath widths
    localparam int A_W     = 20;
    localparam int B_W     = 18;
    localparam int ACC_W   = 64;
    localparam int Z_W     = 38;
    localparam int SHIFT_W = 6;

    // Command word as presented by the requester
    typedef struct packed {
        logic [A_W-1:0]     a;
        logic [B_W-1:0]     b;
        logic               unsigned_a;
        logic               unsigned_b;
        logic               subtract;
        // Add product to accumulator when set, to zero otherwise
        logic               accumulate;
        logic               load_acc;
        logic               round;
        logic               saturate;
        logic [SHIFT_W-1:0] shift;
    } mac_cmd_t;

    // Round, shift and saturate controls
    typedef struct packed {
        logic               round;
        logic               saturate;
        logic [SHIFT_W-1:0] shift;
        // Both operands unsigned
        logic               unsigned_mode;
    } post_ctrl_t;

    // Decoded operation handed to execute
    typedef struct packed {
        logic [ACC_W-1:0] a_ext;
        logic [ACC_W-1:0] b_ext;
        logic             subtract;
        logic             accumulate;
        logic             load_acc;
        post_ctrl_t       post;
    } mac_op_t;

    // Adder output plus the controls that travel with it
    typedef struct packed {
        logic [ACC_W-1:0] sum;
        post_ctrl_t       post;
    } exec_res_t;

endpackage

// ==== src/dsp_mac_decode.sv ====
/*
 * Four-phase req/ack handshake control and command decode.
 * Extends each operand by its own sign flag and issues one op per request.
 */

`timescale 1ns/100ps

module dsp_mac_decode
    import dsp_mac_pkg::*;
(
    input  logic     clock_i,
    input  logic     s_reset,
    input  logic     req_i,
    input  mac_cmd_t cmd_i,
    input  logic     z_valid_i,
    output logic     ack_o,
    output mac_op_t  op_o,
    output logic     op_valid_o
);

    logic    busy;
    logic    accept;
    mac_op_t op_dec;

    // Take a new request only when idle and the last ack has dropped
    assign accept = req_i && !busy && !ack_o;

    // Operand extension to accumulator width
    always_comb begin
        op_dec.a_ext = cmd_i.unsigned_a ?
                       {{(ACC_W-A_W){1'b0}}, cmd_i.a} :
                       {{(ACC_W-A_W){cmd_i.a[A_W-1]}}, cmd_i.a};
        op_dec.b_ext = cmd_i.unsigned_b ?
                       {{(ACC_W-B_W){1'b0}}, cmd_i.b} :
                       {{(ACC_W-B_W){cmd_i.b[B_W-1]}}, cmd_i.b};

        op_dec.subtract   = cmd_i.subtract;
        op_dec.accumulate = cmd_i.accumulate;
        op_dec.load_acc   = cmd_i.load_acc;

        op_dec.post.round         = cmd_i.round;
        op_dec.post.saturate      = cmd_i.saturate;
        op_dec.post.shift         = cmd_i.shift;
        op_dec.post.unsigned_mode = cmd_i.unsigned_a & cmd_i.unsigned_b;
    end

    // Handshake state
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            busy       <= 1'b0;
            ack_o      <= 1'b0;
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= accept;

            if (accept) begin
                busy <= 1'b1;
            end else if (z_valid_i) begin
                busy <= 1'b0;
            end

            // Ack holds until the requester lets go of req
            if (z_valid_i) begin
                ack_o <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (accept) begin
            op_o <= op_dec;
        end
    end

endmodule

// ==== src/dsp_mac_execute.sv ====
/*
 * Execute stage of the MAC slice.
 * Multiplier, optional negate, adder and the 64-bit accumulator.
 */

`timescale 1ns/100ps

module dsp_mac_execute
    import dsp_mac_pkg::*;
(
    input  logic      clock_i,
    input  logic      s_reset,
    input  mac_op_t   op_i,
    input  logic      op_valid_i,
    output exec_res_t res_o,
    output logic      res_valid_o
);

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] product;
    logic [ACC_W-1:0] term;
    logic [ACC_W-1:0] addend;
    logic [ACC_W-1:0] sum;

    // Operands arrive already extended, so the low 64 bits of the
    // product are right for every sign combination
    assign product = op_i.a_ext * op_i.b_ext;

    // Two's complement negate for subtract
    assign term = op_i.subtract ? (~product + 1'b1) : product;

    // Accumulator feedback or a fresh start from zero
    assign addend = op_i.accumulate ? acc : '0;

    assign sum = term + addend;

    // Accumulator
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc <= '0;
        end else if (op_valid_i && op_i.load_acc) begin
            acc <= sum;
        end
    end

    // Valid pulse towards the result stage
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= op_valid_i;
        end
    end

    // Sum and post controls captured together
    always_ff @(posedge clock_i) begin
        if (op_valid_i) begin
            res_o.sum  <= sum;
            res_o.post <= op_i.post;
        end
    end

endmodule

// ==== src/dsp_mac_result.sv ====
/*
 * Result stage of the MAC slice.
 * Rounding, right shift, saturation to 38 bits and the output register.
 */

`timescale 1ns/100ps

module dsp_mac_result
    import dsp_mac_pkg::*;
(
    input  logic            clock_i,
    input  logic            s_reset,
    input  exec_res_t       res_i,
    input  logic            res_valid_i,
    output logic [Z_W-1:0]  z_o,
    output logic            z_valid_o
);

    logic [ACC_W-1:0] rnd_bias;
    logic [ACC_W-1:0] rnd;
    logic [ACC_W-1:0] shr;
    logic [Z_W-1:0]   sat_s;
    logic             over_u;
    logic             over_s;
    logic [Z_W-1:0]   z_next;

    // Half an LSB of the shifted result, only when shifting
    assign rnd_bias = (res_i.post.round && (res_i.post.shift != '0)) ?
                      ({{(ACC_W-1){1'b0}}, 1'b1} << (res_i.post.shift - 1'b1)) :
                      '0;

    assign rnd = res_i.sum + rnd_bias;

    // Logical shift for unsigned, arithmetic otherwise
    always_comb begin
        if (res_i.post.unsigned_mode) begin
            shr = rnd >> res_i.post.shift;
        end else begin
            shr = $signed(rnd) >>> res_i.post.shift;
        end
    end

    // Unsigned overflow if anything sits above bit 37
    assign over_u = |shr[ACC_W-1:Z_W];

    // Signed overflow if bits 63..37 disagree
    assign over_s = !((&shr[ACC_W-1:Z_W-1]) || !(|shr[ACC_W-1:Z_W-1]));
    assign sat_s  = {shr[ACC_W-1], {(Z_W-1){~shr[ACC_W-1]}}};

    always_comb begin
        z_next = shr[Z_W-1:0];
        if (res_i.post.saturate) begin
            if (res_i.post.unsigned_mode) begin
                if (over_u) begin
                    z_next = '1;
                end
            end else if (over_s) begin
                z_next = sat_s;
            end
        end
    end

    // Output register, held until the next result
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_o       <= '0;
            z_valid_o <= 1'b0;
        end else begin
            z_valid_o <= res_valid_i;
            if (res_valid_i) begin
                z_o <= z_next;
            end
        end
    end

endmodule

// ==== src/dsp_mac_top.sv ====
/*
 * Top level of the 20x18 MAC slice.
 * Chains decode, execute and result stages behind a req/ack handshake.
 */

`timescale 1ns/100ps

module dsp_mac_top
    import dsp_mac_pkg::*;
(
    input  logic           clock_i,
    input  logic           s_reset,
    input  logic           req_i,
    input  mac_cmd_t       cmd_i,
    output logic           ack_o,
    output logic [Z_W-1:0] z_o
);

    mac_op_t   op;
    logic      op_valid;
    exec_res_t res;
    logic      res_valid;
    logic      z_valid;

    dsp_mac_decode i_decode (
        .clock_i    (clock_i),
        .s_reset    (s_reset),
        .req_i      (req_i),
        .cmd_i      (cmd_i),
        .z_valid_i  (z_valid),
        .ack_o      (ack_o),
        .op_o       (op),
        .op_valid_o (op_valid)
    );

    dsp_mac_execute i_execute (
        .clock_i     (clock_i),
        .s_reset     (s_reset),
        .op_i        (op),
        .op_valid_i  (op_valid),
        .res_o       (res),
        .res_valid_o (res_valid)
    );

    // Result drives z_o straight to the port
    dsp_mac_result i_result (
        .clock_i     (clock_i),
        .s_reset     (s_reset),
        .res_i       (res),
        .res_valid_i (res_valid),
        .z_o         (z_o),
        .z_valid_o   (z_valid)
    );

endmodule

// ==== dv/dsp_mac_sva.sv ====
/*
 * Handshake assertions for the MAC slice top level,
 * bound into every dsp_mac_top instance.
 */

`timescale 1ns/100ps

module dsp_mac_sva
    import dsp_mac_pkg::*;
(
    input logic           clock_i,
    input logic           s_reset,
    input logic           req_i,
    input logic           ack_o,
    input logic [Z_W-1:0] z_o
);

    ack_needs_req: assert property (@(posedge clock_i) disable iff (s_reset)
        $rose(ack_o) |-> req_i)
        else $error("ack_o rose without req_i");

    ack_holds: assert property (@(posedge clock_i) disable iff (s_reset)
        (ack_o && req_i) |=> ack_o)
        else $error("ack_o dropped while req_i was high");

    // Result frozen for the requester while acknowledged
    z_stable: assert property (@(posedge clock_i) disable iff (s_reset)
        ack_o |=> $stable(z_o))
        else $error("z_o changed while ack_o was high");

    ack_release: assert property (@(posedge clock_i) disable iff (s_reset)
        (ack_o && !req_i) |=> !ack_o)
        else $error("ack_o stayed high after req_i went low");

endmodule

bind dsp_mac_top dsp_mac_sva i_sva (
    .clock_i (clock_i),
    .s_reset (s_reset),
    .req_i   (req_i),
    .ack_o   (ack_o),
    .z_o     (z_o)
);

// ==== dv/dsp_mac_tb.sv ====
/*
 * Testbench for the MAC slice: clock, reset, watchdog,
 * reference model, compare task and directed tests.
 */

`timescale 1ns/100ps

module dsp_mac_tb
    import dsp_mac_pkg::*;
;

    localparam int NUM_TXN   = 70;
    localparam int WATCHDOG  = NUM_TXN * 20 + 100;
    localparam int ACK_LIMIT = 20;

    localparam logic [ACC_W-1:0]        U_MAX = (64'd1 << Z_W) - 1;
    localparam logic signed [ACC_W-1:0] S_MAX = (64'sd1 <<< (Z_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] S_MIN = -(64'sd1 <<< (Z_W - 1));

    logic           clock_i;
    logic           s_reset;
    logic           req_i;
    mac_cmd_t       cmd_i;
    logic           ack_o;
    logic [Z_W-1:0] z_o;

    logic [ACC_W-1:0] model_acc;
    int               error_count;
    int               check_count;
    int               tests_run;

    dsp_mac_top i_dut (
        .clock_i (clock_i),
        .s_reset (s_reset),
        .req_i   (req_i),
        .cmd_i   (cmd_i),
        .ack_o   (ack_o),
        .z_o     (z_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #5 clock_i = ~clock_i;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clock_i);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Full product plus accumulator, as a plain signed sum
    function automatic logic [ACC_W-1:0] model_sum(input mac_cmd_t cmd);
        logic signed [ACC_W-1:0] a_val;
        logic signed [ACC_W-1:0] b_val;
        logic signed [ACC_W-1:0] prod;
        if (cmd.unsigned_a) a_val = cmd.a;
        else a_val = $signed(cmd.a);
        if (cmd.unsigned_b) b_val = cmd.b;
        else b_val = $signed(cmd.b);
        prod = a_val * b_val;
        if (cmd.subtract) prod = -prod;
        return cmd.accumulate ? model_acc + prod : prod;
    endfunction

    // Round, shift and range clamp
    function automatic logic [Z_W-1:0] model_post(input logic [ACC_W-1:0] sum,
                                                  input mac_cmd_t cmd);
        logic signed [ACC_W-1:0] val;
        logic                    both_u;
        val    = sum;
        both_u = cmd.unsigned_a && cmd.unsigned_b;
        if (cmd.round && cmd.shift != 0) val = val + (64'sd1 <<< (cmd.shift - 1));
        if (both_u) val = val >> cmd.shift;
        else val = val >>> cmd.shift;
        if (cmd.saturate) begin
            if (both_u) begin
                if ($unsigned(val) > U_MAX) return '1;
            end else if (val > S_MAX) begin
                return S_MAX[Z_W-1:0];
            end else if (val < S_MIN) begin
                return S_MIN[Z_W-1:0];
            end
        end
        return val[Z_W-1:0];
    endfunction

    function automatic mac_cmd_t plain_cmd(input logic [A_W-1:0] a, input logic [B_W-1:0] b);
        mac_cmd_t cmd;
        cmd   = '0;
        cmd.a = a;
        cmd.b = b;
        return cmd;
    endfunction

    // One full four-phase handshake, optionally holding req after ack
    task automatic transact(input mac_cmd_t cmd, input int hold_cycles,
                            output logic [Z_W-1:0] z_seen);
        logic [ACC_W-1:0] sum_exp;
        logic [Z_W-1:0]   z_exp;
        logic [Z_W-1:0]   z_held;
        int               cycles;
        sum_exp = model_sum(cmd);
        z_exp   = model_post(sum_exp, cmd);
        if (cmd.load_acc) model_acc = sum_exp;

        @(posedge clock_i);
        cmd_i <= cmd;
        req_i <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clock_i);
            cycles++;
            @(negedge clock_i);
        end while (!ack_o && cycles < ACK_LIMIT);
        if (!ack_o) begin
            error_count++;
            $display("No acknowledge within %0d cycles of the request", ACK_LIMIT);
        end
        check_value("ack latency", 64'(cycles), 64'd4);
        check_value("z_o", 64'(z_o), 64'(z_exp));
        z_seen = z_o;
        z_held = z_o;

        repeat (hold_cycles) begin
            @(negedge clock_i);
            check_value("ack_o held", 64'(ack_o), 64'd1);
            check_value("z_o held", 64'(z_o), 64'(z_held));
        end

        @(posedge clock_i);
        req_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock_i);
            cycles++;
            @(negedge clock_i);
        end while (ack_o && cycles < ACK_LIMIT);
        if (ack_o) begin
            error_count++;
            $display("Acknowledge stayed high after the request was dropped");
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, error_count - errs_before);
    endtask

    task automatic test_signed_multiply();
        logic [Z_W-1:0] z;
        int             errs;
        errs = error_count;
        transact(plain_cmd(20'h80000, 18'h20000), 0, z);
        check_value("z_o corner", 64'(z), 64'h10_0000_0000);
        transact(plain_cmd(20'hFFFFF, 18'h1FFFF), 0, z);
        transact(plain_cmd(20'h80000, 18'h1FFFF), 0, z);
        transact(plain_cmd(20'h7FFFF, 18'h20000), 0, z);
        repeat (8) begin
            transact(plain_cmd(A_W'($urandom()), B_W'($urandom())), 0, z);
        end
        report_test("signed multiply", errs);
    endtask

    task automatic test_unsigned_mixed();
        mac_cmd_t       cmd;
        logic [Z_W-1:0] z;
        int             errs;
        errs = error_count;
        for (int mode = 0; mode < 4; mode++) begin
            cmd            = plain_cmd(20'hFFFFF, 18'h3FFFF);
            cmd.unsigned_a = mode[0];
            cmd.unsigned_b = mode[1];
            transact(cmd, 0, z);
            cmd            = plain_cmd(A_W'($urandom()), B_W'($urandom()));
            cmd.unsigned_a = mode[0];
            cmd.unsigned_b = mode[1];
            transact(cmd, 0, z);
        end
        report_test("unsigned and mixed sign", errs);
    endtask

    task automatic test_accumulate();
        mac_cmd_t       cmd;
        logic [Z_W-1:0] z;
        int             errs;
        errs         = error_count;
        cmd          = plain_cmd(20'd1234, 18'd567);
        cmd.load_acc = 1'b1;
        transact(cmd, 0, z);
        repeat (5) begin
            cmd            = plain_cmd(A_W'($urandom()), B_W'($urandom()));
            cmd.accumulate = 1'b1;
            cmd.load_acc   = 1'b1;
            transact(cmd, 0, z);
        end
        // Accumulator must survive a command without load
        cmd            = plain_cmd(A_W'($urandom()), B_W'($urandom()));
        cmd.accumulate = 1'b1;
        transact(cmd, 0, z);
        cmd            = plain_cmd(20'd3, 18'd5);
        cmd.accumulate = 1'b1;
        cmd.load_acc   = 1'b1;
        transact(cmd, 0, z);
        report_test("accumulation", errs);
    endtask

    task automatic test_subtract();
        mac_cmd_t       cmd;
        logic [Z_W-1:0] z;
        int             errs;
        errs         = error_count;
        cmd          = plain_cmd(20'd1000, 18'd1000);
        cmd.load_acc = 1'b1;
        transact(cmd, 0, z);
        repeat (5) begin
            cmd            = plain_cmd(20'd300, 18'd1000);
            cmd.subtract   = 1'b1;
            cmd.accumulate = 1'b1;
            cmd.load_acc   = 1'b1;
            transact(cmd, 0, z);
        end
        // Minus 500000 in 38-bit two's complement
        check_value("z_o below zero", 64'(z), 64'h3F_FFF8_5EE0);
        report_test("subtract", errs);
    endtask

    task automatic test_round_shift_saturate();
        mac_cmd_t       cmd;
        logic [Z_W-1:0] z;
        int             errs;
        errs      = error_count;
        cmd       = plain_cmd(20'd7, 18'd3);
        cmd.round = 1'b1;
        transact(cmd, 0, z);
        check_value("z_o shift 0", 64'(z), 64'd21);
        cmd.shift = 6'd1;
        transact(cmd, 0, z);
        check_value("z_o shift 1", 64'(z), 64'd11);
        cmd       = plain_cmd(20'h40000, 18'd3);
        cmd.round = 1'b1;
        cmd.shift = 6'd20;
        transact(cmd, 0, z);
        check_value("z_o shift 20", 64'(z), 64'd1);
        cmd       = plain_cmd(20'hFFFF9, 18'd3);
        cmd.round = 1'b1;
        cmd.shift = 6'd1;
        transact(cmd, 0, z);
        cmd.round = 1'b0;
        transact(cmd, 0, z);

        // Push the accumulator well past 38 bits, both directions
        cmd          = plain_cmd(20'h80000, 18'h20000);
        cmd.saturate = 1'b1;
        cmd.load_acc = 1'b1;
        transact(cmd, 0, z);
        cmd.accumulate = 1'b1;
        repeat (6) transact(cmd, 0, z);
        check_value("z_o signed max", 64'(z), 64'h1F_FFFF_FFFF);
        cmd.subtract = 1'b1;
        repeat (16) transact(cmd, 0, z);
        check_value("z_o signed min", 64'(z), 64'h20_0000_0000);
        cmd            = plain_cmd(20'd0, 18'd0);
        cmd.accumulate = 1'b1;
        cmd.shift      = 6'd30;
        transact(cmd, 0, z);

        cmd            = plain_cmd(20'hFFFFF, 18'h3FFFF);
        cmd.unsigned_a = 1'b1;
        cmd.unsigned_b = 1'b1;
        cmd.saturate   = 1'b1;
        cmd.load_acc   = 1'b1;
        transact(cmd, 0, z);
        cmd.accumulate = 1'b1;
        transact(cmd, 0, z);
        check_value("z_o unsigned max", 64'(z), 64'h3F_FFFF_FFFF);
        report_test("round shift saturate", errs);
    endtask

    task automatic test_handshake_hold();
        logic [Z_W-1:0] z;
        int             errs;
        errs = error_count;
        transact(plain_cmd(A_W'($urandom()), B_W'($urandom())), 10, z);
        transact(plain_cmd(A_W'($urandom()), B_W'($urandom())), 0, z);
        report_test("handshake hold", errs);
    endtask

    initial begin
        s_reset     = 1'b1;
        req_i       = 1'b0;
        cmd_i       = '0;
        model_acc   = '0;
        error_count = 0;
        check_count = 0;
        tests_run   = 0;
        void'($urandom(32'hc87eefd3));
        repeat (2) @(posedge clock_i);
        s_reset <= 1'b0;

        test_signed_multiply();
        test_unsigned_mixed();
        test_accumulate();
        test_subtract();
        test_round_shift_saturate();
        test_handshake_hold();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/dsp_mac_pkg.sv
src/dsp_mac_decode.sv
src/dsp_mac_execute.sv
src/dsp_mac_result.sv
src/dsp_mac_top.sv
dv/dsp_mac_sva.sv
dv/dsp_mac_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MAC slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dsp_mac_tb \
    -f project.f \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdsp_mac_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
